//--- hw/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
  input wire rv_pkg::alu_op_t op,
  input wire rv_pkg::word_t a,
  input wire rv_pkg::word_t b,
  input wire rv_pkg::br_cond_t cond,
  output rv_pkg::word_t result,
  output logic taken
);
  import rv_pkg::*;

  logic [4:0] shamt;
  logic lt_signed;
  logic lt_unsigned;

  assign shamt = b[4:0];
  assign lt_signed = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (op)
      alu_add: result = a + b;
      alu_sub: result = a - b;
      alu_sll: result = a << shamt;
      alu_slt: result = {{(xlen-1){1'b0}}, lt_signed};
      alu_sltu: result = {{(xlen-1){1'b0}}, lt_unsigned};
      alu_xor: result = a ^ b;
      alu_srl: result = a >> shamt;
      alu_sra: result = $signed(a) >>> shamt;
      alu_or: result = a | b;
      alu_and: result = a & b;
      alu_pass_b: result = b;
      default: result = '0;
    endcase
  end

  // branch condition on the same operands
  always_comb begin
    case (cond)
      br_eq: taken = (a == b);
      br_ne: taken = (a != b);
      br_lt: taken = lt_signed;
      br_ge: taken = !lt_signed;
      br_ltu: taken = lt_unsigned;
      br_geu: taken = !lt_unsigned;
      default: taken = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

//--- hw/core_control.sv
`timescale 1ns/1ps
`default_nettype none

module core_control (
  input wire logic clk,
  input wire logic rst,
  output logic halt,
  mem_req_if.requester fetch_bus,
  mem_req_if.requester data_bus
);
  import rv_pkg::*;

  typedef enum logic [2:0] {
    st_fetch,
    st_fetch_wait,
    st_execute,
    st_mem,
    st_mem_wait,
    st_halted
  } state_t;

  state_t state;
  state_t state_n;
  word_t pc;
  word_t pc_next;
  word_t ir;
  logic fetch_req_q;
  logic data_req_q;

  // instruction fields
  logic [6:0] opcode;
  logic [2:0] f3;
  logic [6:0] f7;
  reg_idx_t rd;
  reg_idx_t rs1;
  reg_idx_t rs2;
  word_t imm_i;
  word_t imm_s;
  word_t imm_b;
  word_t imm_u;
  logic is_load;
  logic is_store;
  logic is_ecall;
  logic is_alu_wb;

  word_t rs1_data;
  word_t rs2_data;
  logic rf_we;
  word_t rf_wdata;
  alu_op_t alu_op;
  word_t alu_b;
  word_t alu_result;
  logic alu_taken;

  assign {f7, rs2, rs1, f3, rd, opcode} = ir;

  assign imm_i = {{20{ir[31]}}, ir[31:20]};
  assign imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
  assign imm_b = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
  assign imm_u = {ir[31:12], 12'b0};

  assign is_load = (opcode == op_load) && (f3 == f3_lw);
  assign is_store = (opcode == op_store) && (f3 == f3_sw);
  assign is_ecall = (opcode == op_system) && (f3 == f3_ecall) && (ir[31:15] == '0)
    && (rd == '0);
  assign is_alu_wb = (opcode == op_lui) || (opcode == op_reg_imm) || (opcode == op_reg_reg);

  function automatic alu_op_t decode_alu(input logic [2:0] funct3, input logic alt);
    alu_op_t sel;
    case (funct3)
      f3_add_sub: sel = alt ? alu_sub : alu_add;
      f3_sll: sel = alu_sll;
      f3_slt: sel = alu_slt;
      f3_sltu: sel = alu_sltu;
      f3_xor: sel = alu_xor;
      f3_srl_sra: sel = alt ? alu_sra : alu_srl;
      f3_or: sel = alu_or;
      default: sel = alu_and;
    endcase
    return sel;
  endfunction

  // operation and second operand; loads and stores add the offset
  always_comb begin
    alu_op = alu_add;
    alu_b = rs2_data;
    case (opcode)
      op_lui: begin
        alu_op = alu_pass_b;
        alu_b = imm_u;
      end
      op_reg_imm: begin
        // addi has no sub form, only the shift uses funct7
        alu_op = decode_alu(f3, (f3 == f3_srl_sra) && (f7 == f7_alt));
        alu_b = imm_i;
      end
      op_reg_reg: begin
        alu_op = decode_alu(f3, f7 == f7_alt);
      end
      op_load: begin
        alu_b = imm_i;
      end
      op_store: begin
        alu_b = imm_s;
      end
      default: begin
        alu_op = alu_add;
      end
    endcase
  end

  assign pc_next = (opcode == op_branch && alu_taken) ? pc + imm_b : pc + 32'd4;

  // writeback from the alu in execute, from memory on load data
  assign rf_we = (state == st_execute && is_alu_wb) || (state == st_mem_wait && data_bus.rvalid);
  assign rf_wdata = (state == st_mem_wait) ? data_bus.rdata : alu_result;

  reg_file u_reg_file (
    .clk(clk),
    .rst(rst),
    .we(rf_we),
    .rd(rd),
    .rd_data(rf_wdata),
    .rs1(rs1),
    .rs2(rs2),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data)
  );

  alu u_alu (
    .op(alu_op),
    .a(rs1_data),
    .b(alu_b),
    .cond(br_cond_t'(f3)),
    .result(alu_result),
    .taken(alu_taken)
  );

  always_comb begin
    state_n = state;
    case (state)
      st_fetch: begin
        if (fetch_bus.gnt) state_n = st_fetch_wait;
      end
      st_fetch_wait: begin
        if (fetch_bus.rvalid) state_n = st_execute;
      end
      st_execute: begin
        if (is_ecall) begin
          state_n = st_halted;
        end else if (is_load || is_store) begin
          state_n = st_mem;
        end else begin
          state_n = st_fetch;
        end
      end
      st_mem: begin
        // a store is done once granted
        if (data_bus.gnt) state_n = is_store ? st_fetch : st_mem_wait;
      end
      st_mem_wait: begin
        if (data_bus.rvalid) state_n = st_fetch;
      end
      default: begin
        state_n = st_halted;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_fetch;
      pc <= '0;
      fetch_req_q <= 1'b0;
      data_req_q <= 1'b0;
    end else begin
      state <= state_n;
      // requests held until granted
      fetch_req_q <= (state_n == st_fetch);
      data_req_q <= (state_n == st_mem);
      if (state == st_execute) pc <= pc_next;
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_fetch_wait && fetch_bus.rvalid) ir <= fetch_bus.rdata;
  end

  assign halt = (state == st_halted);

  assign fetch_bus.req = fetch_req_q;
  assign fetch_bus.we = 1'b0;
  assign fetch_bus.addr = pc;
  assign fetch_bus.wdata = '0;

  // address from rs1 plus offset, stable while in mem
  assign data_bus.req = data_req_q;
  assign data_bus.we = is_store;
  assign data_bus.addr = alu_result;
  assign data_bus.wdata = rs2_data;

endmodule

`default_nettype wire

//--- hw/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
  input wire logic clk,
  input wire logic rst,
  input wire logic host_req,
  input wire logic host_we,
  input wire rv_pkg::word_t host_addr,
  input wire rv_pkg::word_t host_wdata,
  output logic host_gnt,
  output logic host_rvalid,
  output rv_pkg::word_t host_rdata,
  mem_req_if.memory fetch_bus,
  mem_req_if.memory data_bus,
  mem_req_if.requester mem_bus
);
  import rv_pkg::*;

  logic host_sel;
  logic data_sel;
  logic fetch_sel;
  // one-hot owner of the read in flight: host, data, fetch
  logic [2:0] rd_owner_q;

  // fixed priority, host first
  assign host_sel = host_req;
  assign data_sel = !host_req && data_bus.req;
  assign fetch_sel = !host_req && !data_bus.req && fetch_bus.req;

  always_comb begin
    mem_bus.req = host_sel || data_sel || fetch_sel;
    if (host_sel) begin
      mem_bus.we = host_we;
      mem_bus.addr = host_addr;
      mem_bus.wdata = host_wdata;
    end else if (data_sel) begin
      mem_bus.we = data_bus.we;
      mem_bus.addr = data_bus.addr;
      mem_bus.wdata = data_bus.wdata;
    end else begin
      mem_bus.we = fetch_bus.we;
      mem_bus.addr = fetch_bus.addr;
      mem_bus.wdata = fetch_bus.wdata;
    end
  end

  assign host_gnt = host_sel && mem_bus.gnt;
  assign data_bus.gnt = data_sel && mem_bus.gnt;
  assign fetch_bus.gnt = fetch_sel && mem_bus.gnt;

  // remember who owns next cycle's read data
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_owner_q <= 3'b000;
    end else if (mem_bus.gnt && !mem_bus.we) begin
      rd_owner_q <= {host_sel, data_sel, fetch_sel};
    end else begin
      rd_owner_q <= 3'b000;
    end
  end

  assign host_rvalid = mem_bus.rvalid && rd_owner_q[2];
  assign data_bus.rvalid = mem_bus.rvalid && rd_owner_q[1];
  assign fetch_bus.rvalid = mem_bus.rvalid && rd_owner_q[0];

  assign host_rdata = mem_bus.rdata;
  assign data_bus.rdata = mem_bus.rdata;
  assign fetch_bus.rdata = mem_bus.rdata;

endmodule

`default_nettype wire

//--- hw/mem_req_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mem_req_if;
  import rv_pkg::*;

  // requester side
  logic req;
  logic we;
  word_t addr;
  word_t wdata;

  // memory side, rdata qualified by rvalid one cycle after gnt
  logic gnt;
  word_t rdata;
  logic rvalid;

  modport requester (
    output req, we, addr, wdata,
    input gnt, rdata, rvalid
  );

  modport memory (
    input req, we, addr, wdata,
    output gnt, rdata, rvalid
  );

endinterface

`default_nettype wire

//--- hw/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input wire logic clk,
  input wire logic rst,
  input wire logic we,
  input wire rv_pkg::reg_idx_t rd,
  input wire rv_pkg::word_t rd_data,
  input wire rv_pkg::reg_idx_t rs1,
  input wire rv_pkg::reg_idx_t rs2,
  output rv_pkg::word_t rs1_data,
  output rv_pkg::word_t rs2_data
);
  import rv_pkg::*;

  word_t regs [num_regs];

  // x0 always reads zero
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

endmodule

`default_nettype wire

//--- hw/rv_pkg.sv
`default_nettype none

package rv_pkg;

  // datapath and register file sizes
  localparam int xlen = 32;
  localparam int reg_addr_w = 5;
  localparam int num_regs = 32;

  // shared word memory
  localparam int mem_words = 1024;
  // byte address bits that reach the memory
  localparam int mem_addr_w = $clog2(mem_words) + 2;

  typedef logic [xlen-1:0] word_t;
  typedef logic [reg_addr_w-1:0] reg_idx_t;

  // major opcodes of the kept instructions
  localparam logic [6:0] op_lui = 7'b0110111;
  localparam logic [6:0] op_reg_imm = 7'b0010011;
  localparam logic [6:0] op_reg_reg = 7'b0110011;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load = 7'b0000011;
  localparam logic [6:0] op_store = 7'b0100011;
  localparam logic [6:0] op_system = 7'b1110011;

  // funct3 of the alu groups, shared by reg-imm and reg-reg
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll = 3'b001;
  localparam logic [2:0] f3_slt = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or = 3'b110;
  localparam logic [2:0] f3_and = 3'b111;

  // branch conditions
  localparam logic [2:0] f3_beq = 3'b000;
  localparam logic [2:0] f3_bne = 3'b001;
  localparam logic [2:0] f3_blt = 3'b100;
  localparam logic [2:0] f3_bge = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  // word access only
  localparam logic [2:0] f3_lw = 3'b010;
  localparam logic [2:0] f3_sw = 3'b010;

  // ecall is the all-zero system instruction
  localparam logic [2:0] f3_ecall = 3'b000;

  // selects sub and sra
  localparam logic [6:0] f7_alt = 7'b0100000;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b
  } alu_op_t;

  // encoded as the branch funct3, so decode is a cast
  typedef enum logic [2:0] {
    br_eq = 3'b000,
    br_ne = 3'b001,
    br_lt = 3'b100,
    br_ge = 3'b101,
    br_ltu = 3'b110,
    br_geu = 3'b111
  } br_cond_t;

endpackage

`default_nettype wire

//--- hw/rv_system.sv
`timescale 1ns/1ps
`default_nettype none

module rv_system (
  input wire logic clk,
  input wire logic rst,
  input wire logic host_req,
  input wire logic host_we,
  input wire rv_pkg::word_t host_addr,
  input wire rv_pkg::word_t host_wdata,
  output logic host_gnt,
  output logic host_rvalid,
  output rv_pkg::word_t host_rdata,
  output logic halt
);

  // core side requesters and the single memory port
  mem_req_if fetch_bus ();
  mem_req_if data_bus ();
  mem_req_if mem_bus ();

  core_control u_core (
    .clk(clk),
    .rst(rst),
    .halt(halt),
    .fetch_bus(fetch_bus.requester),
    .data_bus(data_bus.requester)
  );

  // host wins over data, data over fetch
  mem_arbiter u_arbiter (
    .clk(clk),
    .rst(rst),
    .host_req(host_req),
    .host_we(host_we),
    .host_addr(host_addr),
    .host_wdata(host_wdata),
    .host_gnt(host_gnt),
    .host_rvalid(host_rvalid),
    .host_rdata(host_rdata),
    .fetch_bus(fetch_bus.memory),
    .data_bus(data_bus.memory),
    .mem_bus(mem_bus.requester)
  );

  word_ram u_ram (
    .clk(clk),
    .rst(rst),
    .bus(mem_bus.memory)
  );

endmodule

`default_nettype wire

//--- hw/word_ram.sv
`timescale 1ns/1ps
`default_nettype none

module word_ram (
  input wire logic clk,
  input wire logic rst,
  mem_req_if.memory bus
);
  import rv_pkg::*;

  word_t mem [mem_words];
  logic [mem_addr_w-3:0] word_idx;

  // byte address to word index
  assign word_idx = bus.addr[mem_addr_w-1:2];

  // single port, never busy
  assign bus.gnt = bus.req;

  always_ff @(posedge clk) begin
    if (bus.req && bus.we) begin
      mem[word_idx] <= bus.wdata;
    end
    if (bus.req && !bus.we) begin
      bus.rdata <= mem[word_idx];
    end
  end

  // read valid pulse, one cycle after the request
  always_ff @(posedge clk) begin
    if (rst) begin
      bus.rvalid <= 1'b0;
    end else begin
      bus.rvalid <= bus.req && !bus.we;
    end
  end

endmodule

`default_nettype wire

//--- rv_system.f
+incdir+verification
hw/rv_pkg.sv
hw/mem_req_if.sv
hw/alu.sv
hw/reg_file.sv
hw/core_control.sv
hw/mem_arbiter.sv
hw/word_ram.sv
hw/rv_system.sv
verification/rv_system_tb.sv

//--- verification/rv_programs.svh
`ifndef RV_PROGRAMS_SVH
`define RV_PROGRAMS_SVH

// instruction encoders for the kept subset
function automatic word_t enc_r(input logic [6:0] f7, input reg_idx_t rs2, input reg_idx_t rs1,
                                input logic [2:0] f3, input reg_idx_t rd);
  return {f7, rs2, rs1, f3, rd, op_reg_reg};
endfunction

function automatic word_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                input logic [2:0] f3, input reg_idx_t rd,
                                input logic [6:0] opcode);
  return {imm, rs1, f3, rd, opcode};
endfunction

function automatic word_t enc_s(input logic [11:0] imm, input reg_idx_t rs2,
                                input reg_idx_t rs1);
  return {imm[11:5], rs2, rs1, f3_sw, imm[4:0], op_store};
endfunction

function automatic word_t enc_b(input logic [12:0] off, input reg_idx_t rs2,
                                input reg_idx_t rs1, input logic [2:0] f3);
  return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
endfunction

function automatic word_t enc_lui(input reg_idx_t rd, input logic [19:0] imm);
  return {imm, rd, op_lui};
endfunction

function automatic word_t enc_ecall();
  return {12'b0, 5'b0, f3_ecall, 5'b0, op_system};
endfunction

function automatic void emit(input word_t w);
  code.push_back(w);
endfunction

// lui plus addi, upper part rounded for the sign of the low part
function automatic void set_reg(input reg_idx_t rd, input word_t v);
  word_t upper;
  upper = (v + 32'h800) >> 12;
  emit(enc_lui(rd, upper[19:0]));
  emit(enc_i(v[11:0], rd, f3_add_sub, rd, op_reg_imm));
endfunction

// next free slot in the result area, addressed off x0
function automatic void store_result(input reg_idx_t rs, input word_t exp);
  int slot;
  slot = results.size() - res_base[cur_prog];
  emit(enc_s(12'(result_area + 4 * slot), rs, 5'd0));
  results.push_back(exp);
endfunction

function automatic void begin_prog(input int k);
  cur_prog = k;
  prog_base[k] = code.size();
  res_base[k] = results.size();
endfunction

function automatic void end_prog();
  emit(enc_ecall());
  prog_len[cur_prog] = code.size() - prog_base[cur_prog];
  res_len[cur_prog] = results.size() - res_base[cur_prog];
endfunction

function automatic void build_imm_prog();
  word_t v;
  word_t b;
  word_t u;
  logic [11:0] imm;
  logic [2:0] f3;
  logic alt;
  begin_prog(0);
  for (int r = 0; r < 2; r++) begin
    u = rand_bits(20);
    emit(enc_lui(5'd1, u[19:0]));
    store_result(5'd1, {u[19:0], 12'b0});
    v = rand_word();
    v[31] = (r == 0);
    set_reg(5'd2, v);
    store_result(5'd2, v);
    // k walks funct3, the last pass is srai
    for (int k = 0; k < 9; k++) begin
      f3 = (k == 8) ? f3_srl_sra : 3'(k);
      alt = (k == 8);
      if (f3 == f3_sll || f3 == f3_srl_sra) begin
        b = rand_bits(5);
        imm = {alt ? f7_alt : 7'b0, b[4:0]};
        b = {27'b0, b[4:0]};
      end else begin
        b = rand_bits(12);
        imm = b[11:0];
        b = {{20{imm[11]}}, imm};
      end
      emit(enc_i(imm, 5'd2, f3, 5'd3, op_reg_imm));
      store_result(5'd3, ref_alu(f3, alt, v, b));
    end
  end
  end_prog();
endfunction

function automatic void build_reg_prog();
  word_t a;
  word_t b;
  logic [2:0] f3;
  logic alt;
  begin_prog(1);
  for (int r = 0; r < 2; r++) begin
    // opposite signs so slt and sltu disagree
    a = rand_word();
    b = rand_word();
    a[31] = (r == 0);
    b[31] = (r != 0);
    set_reg(5'd1, a);
    set_reg(5'd2, b);
    for (int k = 0; k < 10; k++) begin
      f3 = (k < 8) ? 3'(k) : ((k == 8) ? f3_add_sub : f3_srl_sra);
      alt = (k >= 8);
      emit(enc_r(alt ? f7_alt : 7'b0, 5'd2, 5'd1, f3, 5'd3));
      store_result(5'd3, ref_alu(f3, alt, a, b));
    end
    emit(enc_r(7'b0, 5'd2, 5'd1, f3_add_sub, 5'd0));
    store_result(5'd0, '0);
  end
  end_prog();
endfunction

function automatic void build_branch_prog();
  word_t neg;
  word_t pos;
  word_t x;
  word_t y;
  logic [2:0] f3;
  logic [11:0] mark;
  begin_prog(2);
  neg = rand_word() | 32'h8000_0000;
  pos = rand_word() & 32'h7fff_ffff;
  // operand pairs: neg/pos, pos/neg, equal
  for (int p = 0; p < 3; p++) begin
    x = (p == 1) ? pos : neg;
    y = (p == 0) ? pos : neg;
    set_reg(5'd1, x);
    set_reg(5'd2, y);
    for (int c = 0; c < 6; c++) begin
      f3 = (c < 2) ? 3'(c) : 3'(c + 2);
      mark = 12'h100 + 12'(2 * (6 * p + c));
      emit(enc_b(13'd12, 5'd2, 5'd1, f3));
      emit(enc_i(mark, 5'd0, f3_add_sub, 5'd3, op_reg_imm));
      emit(enc_b(13'd8, 5'd0, 5'd0, f3_beq));
      emit(enc_i(mark + 12'd1, 5'd0, f3_add_sub, 5'd3, op_reg_imm));
      store_result(5'd3, {20'b0, ref_taken(f3, x, y) ? mark + 12'd1 : mark});
    end
  end
  end_prog();
endfunction

function automatic void build_mem_prog();
  word_t v;
  word_t w;
  begin_prog(3);
  v = rand_word();
  w = rand_word();
  set_reg(5'd1, v);
  set_reg(5'd7, w);
  set_reg(5'd4, 32'h5f0);
  // store through a base register, load back both ways
  emit(enc_s(12'h010, 5'd1, 5'd4));
  emit(enc_i(12'h600, 5'd0, f3_lw, 5'd2, op_load));
  store_result(5'd2, v);
  emit(enc_i(12'h010, 5'd4, f3_lw, 5'd5, op_load));
  store_result(5'd5, v);
  // negative offset lands at 0x5e0
  emit(enc_s(12'hff0, 5'd7, 5'd4));
  emit(enc_i(12'h5e0, 5'd0, f3_lw, 5'd6, op_load));
  store_result(5'd6, w);
  end_prog();
endfunction

`endif

//--- verification/rv_system_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rv_system_tb;
  import rv_pkg::*;

  localparam int result_area = 'h400;
  localparam int num_progs = 4;

  logic clk;
  logic rst;
  logic host_req;
  logic host_we;
  word_t host_addr;
  word_t host_wdata;
  logic host_gnt;
  logic host_rvalid;
  word_t host_rdata;
  logic halt;

  int checks = 0;
  int errors = 0;
  logic [31:0] lfsr_state = 32'h26a5e584;

  // all programs back to back, with per-program offsets
  word_t code[$];
  word_t results[$];
  int prog_base[num_progs];
  int prog_len[num_progs];
  int res_base[num_progs];
  int res_len[num_progs];
  int cur_prog;
  int watchdog_cycles;
  logic watchdog_armed = 1'b0;

  rv_system dut (
    .clk(clk),
    .rst(rst),
    .host_req(host_req),
    .host_we(host_we),
    .host_addr(host_addr),
    .host_wdata(host_wdata),
    .host_gnt(host_gnt),
    .host_rvalid(host_rvalid),
    .host_rdata(host_rdata),
    .halt(halt)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // galois lfsr, x^32 + x^22 + x^2 + x + 1
  function automatic logic rand_bit();
    logic b;
    b = lfsr_state[0];
    lfsr_state = (lfsr_state >> 1) ^ (b ? 32'h8020_0003 : 32'h0);
    return b;
  endfunction

  function automatic word_t rand_bits(input int n);
    word_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], rand_bit()};
    end
    return v;
  endfunction

  function automatic word_t rand_word();
    return rand_bits(32);
  endfunction

  // RV32I integer rules
  function automatic word_t ref_alu(input logic [2:0] f3, input logic alt, input word_t a,
                                    input word_t b);
    word_t res;
    case (f3)
      f3_add_sub: res = alt ? a - b : a + b;
      f3_sll: res = a << b[4:0];
      f3_slt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      f3_sltu: res = (a < b) ? 32'd1 : 32'd0;
      f3_xor: res = a ^ b;
      f3_or: res = a | b;
      f3_srl_sra: begin
        if (alt) res = $signed(a) >>> b[4:0];
        else res = a >> b[4:0];
      end
      default: res = a & b;
    endcase
    return res;
  endfunction

  function automatic logic ref_taken(input logic [2:0] f3, input word_t a, input word_t b);
    case (f3)
      f3_beq: return a == b;
      f3_bne: return a != b;
      f3_blt: return $signed(a) < $signed(b);
      f3_bge: return $signed(a) >= $signed(b);
      f3_bltu: return a < b;
      f3_bgeu: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  `include "rv_programs.svh"

  // host has top priority, so it never waits
  host_gnt_a: assert property (@(posedge clk) host_req |-> host_gnt)
    else begin
      errors++;
      $display("protocol error at %0t: host request without grant", $time);
    end

  read_valid_a: assert property (@(posedge clk) disable iff (rst)
    host_gnt && !host_we |=> host_rvalid)
    else begin
      errors++;
      $display("protocol error at %0t: host read without rvalid next cycle", $time);
    end

  halt_sticky_a: assert property (@(posedge clk) disable iff (rst) halt |=> halt)
    else begin
      errors++;
      $display("protocol error at %0t: halt dropped without reset", $time);
    end

  halt_quiet_a: assert property (@(posedge clk) disable iff (rst)
    halt |-> !dut.fetch_bus.req && !dut.data_bus.req)
    else begin
      errors++;
      $display("protocol error at %0t: core request while halted", $time);
    end

  task automatic check_word(input word_t got, input word_t exp, input string what);
    checks++;
    assert (got === exp)
      else begin
        errors++;
        $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
      end
  endtask

  // leaves the request up, the next host task's edge commits it
  task automatic host_write(input word_t addr, input word_t data);
    int n;
    n = 0;
    @(posedge clk);
    #2;
    host_req = 1'b1;
    host_we = 1'b1;
    host_addr = addr;
    host_wdata = data;
    @(negedge clk);
    while (!host_gnt && n < 8) begin
      @(negedge clk);
      n++;
    end
    if (!host_gnt) begin
      errors++;
      $display("host write to %h was never granted", addr);
    end
  endtask

  task automatic host_read(input word_t addr, output word_t data);
    int n;
    n = 0;
    @(posedge clk);
    #2;
    host_req = 1'b1;
    host_we = 1'b0;
    host_addr = addr;
    @(negedge clk);
    while (!host_gnt && n < 8) begin
      @(negedge clk);
      n++;
    end
    if (!host_gnt) begin
      errors++;
      $display("host read of %h was never granted", addr);
    end
    @(posedge clk);
    #2;
    host_req = 1'b0;
    @(negedge clk);
    checks++;
    assert (host_rvalid)
      else begin
        errors++;
        $display("FAIL %0t: no host_rvalid on the cycle after grant for %h", $time, addr);
      end
    data = host_rdata;
  endtask

  task automatic hold_reset();
    @(posedge clk);
    #2;
    rst = 1'b1;
    host_req = 1'b0;
    repeat (2) @(posedge clk);
  endtask

  task automatic release_reset();
    @(posedge clk);
    #2;
    host_req = 1'b0;
    rst = 1'b0;
  endtask

  // poll for halt, optionally with random host reads of the code
  task automatic wait_halt(input int limit, input int k, input bit traffic);
    int waited;
    int idx;
    word_t got;
    waited = 0;
    while (!halt && waited < limit) begin
      if (traffic && rand_bit()) begin
        idx = int'(rand_bits(8)) % prog_len[k];
        host_read(word_t'(4 * idx), got);
        check_word(got, code[prog_base[k] + idx],
                   $sformatf("host read of code word %0d during run", idx));
        waited += 3;
      end else begin
        @(negedge clk);
        waited++;
      end
    end
    if (!halt) begin
      errors++;
      $display("core did not halt within %0d cycles", limit);
    end
  endtask

  task automatic run_program(input int k, input bit traffic);
    word_t got;
    word_t addr;
    hold_reset();
    for (int i = 0; i < prog_len[k]; i++) begin
      host_write(word_t'(4 * i), code[prog_base[k] + i]);
    end
    // stale slots must not pass, pattern from the whole address
    for (int j = 0; j < res_len[k]; j++) begin
      addr = word_t'(result_area + 4 * j);
      host_write(addr, ~addr ^ {addr[7:0], addr[31:8]});
    end
    release_reset();
    wait_halt(40 * prog_len[k] + 500, k, traffic);
    for (int j = 0; j < res_len[k]; j++) begin
      host_read(word_t'(result_area + 4 * j), got);
      check_word(got, results[res_base[k] + j], $sformatf("program %0d result %0d", k, j));
    end
    checks++;
    assert (halt)
      else begin
        errors++;
        $display("FAIL %0t: halt low after program %0d", $time, k);
      end
  endtask

  initial begin
    word_t got;
    word_t v1;
    word_t v2;
    rst = 1'b1;
    host_req = 1'b0;
    host_we = 1'b0;
    host_addr = '0;
    host_wdata = '0;
    build_imm_prog();
    build_reg_prog();
    build_branch_prog();
    build_mem_prog();
    // branch program runs twice, plus the one-word ecall program
    watchdog_cycles = 40 * (code.size() + prog_len[2] + 1) + 500;
    watchdog_armed = 1'b1;

    repeat (2) @(posedge clk);
    @(negedge clk);
    check_word({29'b0, halt, host_gnt, host_rvalid}, '0, "halt, host_gnt, host_rvalid");
    host_write('0, enc_ecall());
    release_reset();
    wait_halt(500, 0, 1'b0);
    v1 = rand_word();
    v2 = rand_word();
    host_write(32'h700, v1);
    host_write(32'h704, v2);
    host_read(32'h700, got);
    check_word(got, v1, "host read of 0x700");
    host_read(32'h704, got);
    check_word(got, v2, "host read of 0x704");

    run_program(0, 1'b0);
    run_program(1, 1'b0);
    run_program(2, 1'b0);
    run_program(3, 1'b0);
    run_program(2, 1'b1);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin
    wait (watchdog_armed);
    repeat (watchdog_cycles) @(posedge clk);
    $display("timeout: run not finished after %0d cycles", watchdog_cycles);
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire
